/* design/tcb_macros.svh */
/*
 * TCB subsystem sizing
 * bus width, address width and memory lane geometry
 */

`ifndef TCB_MACROS_SVH
`define TCB_MACROS_SVH

// bus data width in bytes
`define TCB_DATA_BYTES 4
// bus data width in bits, derived
`define TCB_DATA_WIDTH (`TCB_DATA_BYTES*8)

// byte address width
`define TCB_ADDR_WIDTH 16

// number of memory lanes behind the decoder
`define TCB_LANES 4
// words per lane memory
`define TCB_MEM_WORDS 256

// request to response latency, memory cycle plus slice cycle
`define TCB_RSP_DLY 2

`endif

/* design/tcb_bus_pkg.sv */
/*
 * TCB bus types
 * request and response payloads shared by manager and subordinates
 */

`include "tcb_macros.svh"

package tcb_bus_pkg;

    //////////////////////////////////////////////////
    // access size
    //////////////////////////////////////////////////

    // log2 of the byte count
    // 0 byte, 1 half word, 2 word
    typedef logic [1:0] tcb_siz_t;

    //////////////////////////////////////////////////
    // request
    //////////////////////////////////////////////////

    typedef struct packed {
        // write enable
        logic                        wen;
        // read enable
        logic                        ren;
        // byte address
        logic [`TCB_ADDR_WIDTH-1:0]  adr;
        // access size
        tcb_siz_t                    siz;
        // write data, placed from byte 0
        logic [`TCB_DATA_WIDTH-1:0]  wdt;
    } tcb_req_t;

    //////////////////////////////////////////////////
    // response
    //////////////////////////////////////////////////

    typedef struct packed {
        // read data, addressed bytes at byte 0
        logic [`TCB_DATA_WIDTH-1:0]  rdt;
        // error flag
        logic                        err;
    } tcb_rsp_t;

endpackage

/* design/tcb_map_pkg.sv */
/*
 * TCB address map
 * address field split and the lane routing types
 */

`include "tcb_macros.svh"

package tcb_map_pkg;

    // byte offset within a word, lowest bits
    localparam int unsigned ADR_OFF_W = $clog2(`TCB_DATA_BYTES);
    // word within a lane
    localparam int unsigned WRD_LSB   = ADR_OFF_W;
    localparam int unsigned WRD_W     = $clog2(`TCB_MEM_WORDS);
    // lane select
    localparam int unsigned LANE_LSB  = WRD_LSB + WRD_W;
    localparam int unsigned LANE_W    = $clog2(`TCB_LANES);
    // any set bit in this range is a miss
    localparam int unsigned MIS_LSB   = LANE_LSB + LANE_W;
    localparam int unsigned MIS_MSB   = `TCB_ADDR_WIDTH - 1;

    // lane index
    typedef logic [LANE_W-1:0] lane_idx_t;

    // route of one request, used by the response mux
    typedef struct packed {
        logic      mis;
        lane_idx_t idx;
    } route_t;

endpackage

/* design/tcb_decoder.sv */
/*
 * TCB address decoder
 * routes each request to a single lane strobe or flags a miss
 */

`timescale 1ns/10ps

`include "tcb_macros.svh"

module tcb_decoder (
    // clock and reset, only used by the checks
    input  logic                   man,
    input  logic                   arst_n,
    // manager side
    input  logic                   vld,
    input  tcb_bus_pkg::tcb_req_t  req,
    // lane strobes
    output logic [`TCB_LANES-1:0]  lane_vld,
    // route info for the response mux
    output tcb_map_pkg::route_t    route
);

    //////////////////////////////////////////////////
    // address fields
    //////////////////////////////////////////////////

    tcb_map_pkg::lane_idx_t lane_idx;
    logic                   lane_mis;

    // lane bits sit right above the word bits
    assign lane_idx = req.adr[tcb_map_pkg::LANE_LSB +: tcb_map_pkg::LANE_W];

    // upper address bits must all be clear
    assign lane_mis = |req.adr[tcb_map_pkg::MIS_MSB:tcb_map_pkg::MIS_LSB];

    assign route.idx = lane_idx;
    assign route.mis = lane_mis;

    //////////////////////////////////////////////////
    // lane strobes
    //////////////////////////////////////////////////

    always_comb begin
        lane_vld = '0;
        // a miss reaches no lane
        if (vld && !lane_mis) begin
            for (int k = 0; k < `TCB_LANES; k++) begin
                if (int'(lane_idx) == k) begin
                    lane_vld[k] = 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // never more than one lane selected
    a_lane_onehot0: assert property (
        @(posedge man) disable iff (!arst_n)
        $onehot0(lane_vld)
    ) else $error("decoder selected more than one lane: %b", lane_vld);

endmodule

/* design/tcb_memory.sv */
/*
 * TCB memory subordinate
 * byte addressed storage, response registered one cycle after the request
 */

`timescale 1ns/10ps

`include "tcb_macros.svh"

module tcb_memory (
    input  logic                   man,
    input  logic                   arst_n,
    // request side
    input  logic                   vld,
    input  tcb_bus_pkg::tcb_req_t  req,
    // response side
    output tcb_bus_pkg::tcb_rsp_t  rsp,
    output logic                   trn_dly
);

    localparam int unsigned OFF_W = tcb_map_pkg::ADR_OFF_W;

    // word array, one entry per byte lane
    logic [7:0] mem [`TCB_MEM_WORDS][`TCB_DATA_BYTES];

    logic [OFF_W-1:0]                off;
    logic [tcb_map_pkg::WRD_W-1:0]   wrd;
    logic                            mis_aln;
    logic [`TCB_DATA_WIDTH-1:0]      rdt_nxt;

    assign off = req.adr[OFF_W-1:0];
    assign wrd = req.adr[tcb_map_pkg::WRD_LSB +: tcb_map_pkg::WRD_W];

    //////////////////////////////////////////////////
    // alignment
    //////////////////////////////////////////////////

    always_comb begin
        // wider than the bus is an error too
        mis_aln = (int'(req.siz) > OFF_W);
        // offset bits below the size must be zero
        for (int i = 0; i < OFF_W; i++) begin
            if ((i < int'(req.siz)) && off[i]) begin
                mis_aln = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // storage access
    //////////////////////////////////////////////////

    // addressed bytes shifted down to byte 0
    always_comb begin
        rdt_nxt = '0;
        if (!mis_aln) begin
            for (int i = 0; i < `TCB_DATA_BYTES; i++) begin
                if (i < (1 << req.siz)) begin
                    rdt_nxt[8*i +: 8] = mem[wrd][OFF_W'(int'(off) + i)];
                end
            end
        end
    end

    // write bytes from byte 0 of wdt to the addressed offset
    always_ff @(posedge man) begin
        if (vld && req.wen && !mis_aln) begin
            for (int i = 0; i < `TCB_DATA_BYTES; i++) begin
                if (i < (1 << req.siz)) begin
                    mem[wrd][OFF_W'(int'(off) + i)] <= req.wdt[8*i +: 8];
                end
            end
        end
    end

    // response payload
    always_ff @(posedge man) begin
        if (vld) begin
            rsp.rdt <= rdt_nxt;
            rsp.err <= mis_aln;
        end
    end

    // transfer marker, one cycle behind the request
    always_ff @(posedge man or negedge arst_n) begin
        if (!arst_n) begin
            trn_dly <= 1'b0;
        end else begin
            trn_dly <= vld;
        end
    end

    // a transfer is either a read or a write
    a_wen_ren_excl: assert property (
        @(posedge man) disable iff (!arst_n)
        vld |-> !(req.wen && req.ren)
    ) else $error("memory got wen and ren together");

endmodule

/* design/tcb_register_response.sv */
/*
 * TCB response register slice
 * one extra cycle on the response, only the read bytes in use are loaded
 */

`timescale 1ns/10ps

`include "tcb_macros.svh"

module tcb_register_response (
    input  logic                   man,
    input  logic                   arst_n,
    // transfer marker from the memory
    input  logic                   trn_dly,
    // request as seen by the memory
    input  tcb_bus_pkg::tcb_req_t  req,
    // memory response
    input  tcb_bus_pkg::tcb_rsp_t  rsp_in,
    // registered response
    output tcb_bus_pkg::tcb_rsp_t  rsp
);

    //////////////////////////////////////////////////
    // delayed request fields
    //////////////////////////////////////////////////

    // memory request has moved on by the time
    // its response shows up, so keep what we need
    logic                   ren_dly;
    tcb_bus_pkg::tcb_siz_t  siz_dly;

    always_ff @(posedge man or negedge arst_n) begin
        if (!arst_n) begin
            ren_dly <= 1'b0;
            siz_dly <= '0;
        end else begin
            ren_dly <= req.ren;
            siz_dly <= req.siz;
        end
    end

    //////////////////////////////////////////////////
    // response registers
    //////////////////////////////////////////////////

    always_ff @(posedge man or negedge arst_n) begin
        if (!arst_n) begin
            rsp <= '0;
        end else begin
            // error follows every transfer
            if (trn_dly) begin
                rsp.err <= rsp_in.err;
            end
            // read data only for bytes covered by the size
            // upper bytes hold their old value
            if (trn_dly && ren_dly) begin
                for (int i = 0; i < `TCB_DATA_BYTES; i++) begin
                    if (i < (1 << siz_dly)) begin
                        rsp.rdt[8*i +: 8] <= rsp_in.rdt[8*i +: 8];
                    end
                end
            end
        end
    end

endmodule

/* design/tcb_response_mux.sv */
/*
 * TCB response multiplexer
 * follows lane indexes through the pipeline and picks the answering lane
 */

`timescale 1ns/10ps

`include "tcb_macros.svh"

module tcb_response_mux (
    input  logic                   man,
    input  logic                   arst_n,
    // request side route info
    input  logic                   vld,
    input  tcb_map_pkg::route_t    route,
    // lane responses
    input  tcb_bus_pkg::tcb_rsp_t  lane_rsp [`TCB_LANES],
    // manager side response
    output logic                   rsp_vld,
    output tcb_bus_pkg::tcb_rsp_t  rsp
);

    //////////////////////////////////////////////////
    // route pipeline
    //////////////////////////////////////////////////

    // one stage per response cycle
    logic                 vld_q   [`TCB_RSP_DLY];
    tcb_map_pkg::route_t  route_q [`TCB_RSP_DLY];

    always_ff @(posedge man or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < `TCB_RSP_DLY; s++) begin
                vld_q[s]   <= 1'b0;
                route_q[s] <= '0;
            end
        end else begin
            vld_q[0]   <= vld;
            route_q[0] <= route;
            for (int s = 1; s < `TCB_RSP_DLY; s++) begin
                vld_q[s]   <= vld_q[s-1];
                route_q[s] <= route_q[s-1];
            end
        end
    end

    //////////////////////////////////////////////////
    // response select
    //////////////////////////////////////////////////

    assign rsp_vld = vld_q[`TCB_RSP_DLY-1];

    always_comb begin
        // miss, no lane answered
        if (route_q[`TCB_RSP_DLY-1].mis) begin
            rsp.rdt = '0;
            rsp.err = 1'b1;
        end else begin
            rsp = lane_rsp[route_q[`TCB_RSP_DLY-1].idx];
        end
    end

    a_rsp_vld_known: assert property (
        @(posedge man) disable iff (!arst_n)
        !$isunknown(rsp_vld)
    ) else $error("rsp_vld is unknown");

endmodule

/* design/tcb_subsystem.sv */
/*
 * TCB subsystem top
 * decoder, four memory lanes with response slices and the response mux
 */

`timescale 1ns/10ps

`include "tcb_macros.svh"

module tcb_subsystem (
    input  logic                   man,
    input  logic                   arst_n,
    // manager request
    input  logic                   vld,
    input  tcb_bus_pkg::tcb_req_t  req,
    // manager response, two cycles later
    output logic                   rsp_vld,
    output tcb_bus_pkg::tcb_rsp_t  rsp
);

    logic [`TCB_LANES-1:0]   lane_vld;
    tcb_map_pkg::route_t     route;

    // per lane memory and slice outputs
    tcb_bus_pkg::tcb_rsp_t   mem_rsp     [`TCB_LANES];
    logic                    mem_trn_dly [`TCB_LANES];
    tcb_bus_pkg::tcb_rsp_t   slc_rsp     [`TCB_LANES];

    //////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////

    tcb_decoder u_decoder (
        .man      (man),
        .arst_n   (arst_n),
        .vld      (vld),
        .req      (req),
        .lane_vld (lane_vld),
        .route    (route)
    );

    //////////////////////////////////////////////////
    // memory lanes
    //////////////////////////////////////////////////

    // request fans out to every lane, only the strobe differs
    for (genvar k = 0; k < `TCB_LANES; k++) begin : g_lane

        tcb_memory u_memory (
            .man     (man),
            .arst_n  (arst_n),
            .vld     (lane_vld[k]),
            .req     (req),
            .rsp     (mem_rsp[k]),
            .trn_dly (mem_trn_dly[k])
        );

        tcb_register_response u_slice (
            .man     (man),
            .arst_n  (arst_n),
            .trn_dly (mem_trn_dly[k]),
            .req     (req),
            .rsp_in  (mem_rsp[k]),
            .rsp     (slc_rsp[k])
        );

    end

    //////////////////////////////////////////////////
    // response return
    //////////////////////////////////////////////////

    tcb_response_mux u_rsp_mux (
        .man      (man),
        .arst_n   (arst_n),
        .vld      (vld),
        .route    (route),
        .lane_rsp (slc_rsp),
        .rsp_vld  (rsp_vld),
        .rsp      (rsp)
    );

endmodule

/* sim/tb_tcb_subsystem.sv */
/*
 * TCB subsystem testbench
 * directed tests checked against a byte level model of the lanes
 */

`timescale 1ns/10ps

`include "tcb_macros.svh"

module tb_tcb_subsystem;

    localparam int CLK_PERIOD  = 40;
    localparam int LANE_BYTES  = `TCB_MEM_WORDS * `TCB_DATA_BYTES;
    // words per lane touched by the tests and written first
    localparam int TEST_WORDS  = 8;
    localparam int RAND_CYCLES = 200;
    // watchdog budget of every test plus drain slack
    localparam int TOTAL_CYCLES = 4 + 8 + 2 * `TCB_LANES * TEST_WORDS
                                + 16 * `TCB_LANES + 8 * `TCB_LANES + 12
                                + RAND_CYCLES + 6 * 8;

    logic                   man;
    logic                   arst_n;
    logic                   vld;
    tcb_bus_pkg::tcb_req_t  req;
    logic                   rsp_vld;
    tcb_bus_pkg::tcb_rsp_t  rsp;

    int    errors;
    int    checks;
    int    pending;
    string test_name;

    // model of the lane bytes and of every lane slice register
    logic [7:0]                  mdl_mem [`TCB_LANES][LANE_BYTES];
    logic [`TCB_DATA_WIDTH-1:0]  mdl_rdt [`TCB_LANES];
    logic                        mdl_err [`TCB_LANES];

    // predictions waiting for the DUT in issue order
    logic                   exp_vld_q  [$];
    tcb_bus_pkg::tcb_rsp_t  exp_rsp_q  [$];
    string                  exp_name_q [$];

    initial man = 1'b0;
    always #(CLK_PERIOD / 2) man = ~man;

    tcb_subsystem u_dut (
        .man     (man),
        .arst_n  (arst_n),
        .vld     (vld),
        .req     (req),
        .rsp_vld (rsp_vld),
        .rsp     (rsp)
    );

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // lane, word and byte offset packed into a bus address
    function automatic logic [15:0] lane_adr(input int lane, input int word, input int off);
        return 16'((lane << 10) | (word << 2) | off);
    endfunction

    // data derived from the full address
    function automatic logic [31:0] pattern(input logic [15:0] a);
        return {a ^ 16'h5a3c, ~a};
    endfunction

    // expected response of one request and the model update
    task automatic predict(input logic v, input tcb_bus_pkg::tcb_req_t r,
                           output logic ev, output tcb_bus_pkg::tcb_rsp_t er);
        int   lane;
        int   base;
        int   n;
        logic aln;
        ev = v;
        er = '0;
        if (!v) return;
        // any of bits 15..12 set means no lane is touched
        if (r.adr[15:12] != 4'h0) begin
            er.err = 1'b1;
            return;
        end
        lane = int'(r.adr[11:10]);
        base = int'(r.adr[9:0]);
        n    = 1 << r.siz;
        aln  = (n <= `TCB_DATA_BYTES) && (base % n == 0);
        // slice takes err on every transfer
        mdl_err[lane] = !aln;
        for (int i = 0; i < `TCB_DATA_BYTES; i++) begin
            if (i < n) begin
                if (aln && r.wen) mdl_mem[lane][base + i] = r.wdt[8*i +: 8];
                // misaligned read data is zero
                // upper bytes keep their old value
                if (r.ren) mdl_rdt[lane][8*i +: 8] = aln ? mdl_mem[lane][base + i] : 8'h00;
            end
        end
        er.rdt = mdl_rdt[lane];
        er.err = mdl_err[lane];
    endtask

    // one request driven on the rising edge
    task automatic issue(input logic w, input tcb_bus_pkg::tcb_siz_t s,
                         input logic [15:0] a, input logic [31:0] d);
        tcb_bus_pkg::tcb_req_t r;
        r.wen = w;
        r.ren = !w;
        r.adr = a;
        r.siz = s;
        r.wdt = d;
        @(posedge man);
        vld <= 1'b1;
        req <= r;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge man);
            vld <= 1'b0;
        end
    endtask

    // wait until every predicted response was seen
    task automatic drain();
        idle(1);
        while (pending != 0) @(posedge man);
    endtask

    //////////////////////////////////////////////////
    // response monitor
    //////////////////////////////////////////////////

    // inputs seen at a falling edge are answered two falling edges later
    initial begin
        logic                   ev;
        tcb_bus_pkg::tcb_rsp_t  er;
        wait (arst_n === 1'b1);
        repeat (`TCB_RSP_DLY) begin
            exp_vld_q.push_back(1'b0);
            exp_rsp_q.push_back('0);
            exp_name_q.push_back("reset");
        end
        forever begin
            @(negedge man);
            predict(vld, req, ev, er);
            exp_vld_q.push_back(ev);
            exp_rsp_q.push_back(er);
            exp_name_q.push_back(test_name);
            if (ev) pending++;
            ev = exp_vld_q.pop_front();
            er = exp_rsp_q.pop_front();
            compare({exp_name_q[0], " rsp_vld"}, 64'(ev), 64'(rsp_vld));
            if (ev) begin
                compare({exp_name_q[0], " rdt"}, 64'(er.rdt), 64'(rsp.rdt));
                compare({exp_name_q[0], " err"}, 64'(er.err), 64'(rsp.err));
                pending--;
            end
            void'(exp_name_q.pop_front());
        end
    end

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////

    task automatic reset_idle();
        test_name = "reset idle";
        // monitor expects rsp_vld low throughout
        idle(8);
    endtask

    task automatic word_write_read();
        test_name = "word rw";
        for (int l = 0; l < `TCB_LANES; l++)
            for (int w = 0; w < TEST_WORDS; w++)
                issue(1'b1, 2'd2, lane_adr(l, w, 0), pattern(lane_adr(l, w, 0)));
        for (int l = 0; l < `TCB_LANES; l++)
            for (int w = 0; w < TEST_WORDS; w++)
                issue(1'b0, 2'd2, lane_adr(l, w, 0), 32'h0);
        drain();
    endtask

    task automatic sub_word_access();
        test_name = "byte and half";
        for (int l = 0; l < `TCB_LANES; l++) begin
            // bytes at every offset and their read back
            for (int o = 0; o < 4; o++) issue(1'b1, 2'd0, lane_adr(l, 3, o), $urandom);
            issue(1'b0, 2'd2, lane_adr(l, 3, 0), 32'h0);
            for (int o = 0; o < 4; o++) issue(1'b0, 2'd0, lane_adr(l, 3, o), 32'h0);
            // half words keep the upper slice bytes of the last read
            issue(1'b1, 2'd1, lane_adr(l, 4, 0), $urandom);
            issue(1'b1, 2'd1, lane_adr(l, 4, 2), $urandom);
            issue(1'b0, 2'd1, lane_adr(l, 4, 2), 32'h0);
            issue(1'b0, 2'd1, lane_adr(l, 4, 0), 32'h0);
            issue(1'b0, 2'd2, lane_adr(l, 4, 0), 32'h0);
        end
        drain();
    endtask

    task automatic misaligned_access();
        test_name = "misaligned";
        for (int l = 0; l < `TCB_LANES; l++) begin
            issue(1'b1, 2'd1, lane_adr(l, 5, 1), 32'hdead_beef);
            issue(1'b1, 2'd2, lane_adr(l, 5, 2), 32'hcafe_f00d);
            issue(1'b0, 2'd1, lane_adr(l, 5, 3), 32'h0);
            issue(1'b0, 2'd2, lane_adr(l, 5, 1), 32'h0);
            // memory must be untouched
            issue(1'b0, 2'd2, lane_adr(l, 5, 0), 32'h0);
        end
        drain();
    endtask

    task automatic address_miss();
        test_name = "miss";
        issue(1'b1, 2'd2, 16'h1000, 32'h1234_5678);
        issue(1'b0, 2'd2, 16'h8004, 32'h0);
        issue(1'b0, 2'd0, 16'hf3fd, 32'h0);
        issue(1'b1, 2'd1, 16'h2402, 32'h0000_abcd);
        // same lane bits without the miss bit read the old data
        issue(1'b0, 2'd2, 16'h0000, 32'h0);
        drain();
    endtask

    task automatic random_traffic();
        logic [1:0] siz;
        int         off;
        test_name = "random";
        for (int c = 0; c < RAND_CYCLES; c++) begin
            if ($urandom_range(0, 3) == 0) begin
                idle(1);
            end else begin
                siz = 2'($urandom_range(0, 2));
                off = int'($urandom_range(0, 3)) & ~((1 << siz) - 1);
                issue(1'($urandom_range(0, 1)), siz,
                      lane_adr(int'($urandom_range(0, 3)), int'($urandom_range(0, 7)), off),
                      $urandom);
            end
        end
        drain();
    endtask

    //////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(32'he6091d56));
        errors    = 0;
        checks    = 0;
        pending   = 0;
        test_name = "none";
        vld       = 1'b0;
        req       = '0;
        arst_n    = 1'b0;
        for (int l = 0; l < `TCB_LANES; l++) begin
            mdl_rdt[l] = '0;
            mdl_err[l] = 1'b0;
        end
        repeat (4) @(posedge man);
        arst_n <= 1'b1;
        reset_idle();
        word_write_read();
        sub_word_access();
        misaligned_access();
        address_miss();
        random_traffic();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD + 100 * CLK_PERIOD);
        $display("watchdog expired with %0d responses still missing", pending);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* src.f */
+incdir+design
design/tcb_bus_pkg.sv
design/tcb_map_pkg.sv
design/tcb_decoder.sv
design/tcb_memory.sv
design/tcb_register_response.sv
design/tcb_response_mux.sv
design/tcb_subsystem.sv
sim/tb_tcb_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= tb_tcb_subsystem
DUT_TOP   ?= tcb_subsystem
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
